// File: Bender.yml
package:
  name: spi_master

sources:
  - spi_pkg.sv
  - spi_clk_timer.sv
  - spi_ctrl_fsm.sv
  - spi_shift_reg.sv
  - spi_master_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - spi_slave_model.sv
      - tb_spi_master.sv

// File: sources.f
spi_pkg.sv
spi_clk_timer.sv
spi_ctrl_fsm.sv
spi_shift_reg.sv
spi_master_top.sv
tb_clk_gen.sv
spi_slave_model.sv
tb_spi_master.sv

// File: spi_clk_timer.sv
// spi clock timer, counts sys clocks per sclk half period and counts sclk edges
`timescale 1ns/1ps
`default_nettype none

module spi_clk_timer #(
	parameter  int data_w = 8,
	localparam int edge_w = $clog2(2 * data_w + 1)
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,

	input  logic [spi_pkg::div_w-1:0] clk_div,	// half-period divider
	input  logic                     div_run,	// count while waiting
	input  logic                     edge_step,	// one sclk edge this cycle
	input  logic                     xfer_start,	// new transfer accepted

	output logic                     div_done,	// half period elapsed
	output logic                     last_edge,	// current edge is the final one
	output logic [edge_w-1:0]        edge_idx	// zero-based edge number
);

	import spi_pkg::*;

	localparam int last_idx = 2 * data_w - 1;

	logic [div_w-1:0]  cnt_clk;	// sys clocks within the half period
	logic [edge_w-1:0] cnt_edge;	// sclk edges so far

	// divider, runs only during the wait states
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt_clk <= '0;
		end else if (div_run) begin
			cnt_clk <= cnt_clk + 1'b1;
		end else begin
			cnt_clk <= '0;
		end
	end

	assign div_done = (cnt_clk == clk_div);

	// edge counter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt_edge <= '0;
		end else if (xfer_start) begin
			cnt_edge <= '0;	// restart per transfer
		end else if (edge_step) begin
			cnt_edge <= cnt_edge + 1'b1;
		end
	end

	assign edge_idx  = cnt_edge;
	assign last_edge = (cnt_edge == edge_w'(last_idx));

	// the fsm must leave the edge loop after edge 2*data_w-1
	a_edge_bound: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		edge_step |-> (cnt_edge <= edge_w'(last_idx))
	) else $error("sclk edge stepped past the last edge of the word");

endmodule

`default_nettype wire

// File: spi_ctrl_fsm.sv
// spi transfer sequencer, generates sclk, timer controls and the wr_ack pulse
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_fsm (
	input  logic              sys_clk,
	input  logic              sys_rst_n,

	input  spi_pkg::spi_cfg_t cfg,		// cpol is used here
	input  logic              wr_req,	// level request
	input  logic              div_done,	// from timer
	input  logic              last_edge,	// from timer

	output logic              div_run,	// timer divider enable
	output logic              edge_step,	// sclk edge strobe
	output logic              xfer_start,	// request accepted in idle
	output logic              sclk,
	output logic              wr_ack	// one-cycle acknowledge
);

	import spi_pkg::*;

	spi_state_e state;
	spi_state_e state_nxt;

	// state register
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= s_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			s_idle: begin
				if (wr_req) begin
					state_nxt = s_sclk_wait;
				end
			end
			s_sclk_wait: begin
				if (div_done) begin
					state_nxt = s_sclk_edge;
				end
			end
			s_sclk_edge: begin
				if (last_edge) begin
					state_nxt = s_last_half;	// word done, hold one half period
				end else begin
					state_nxt = s_sclk_wait;
				end
			end
			s_last_half: begin
				if (div_done) begin
					state_nxt = s_ack;
				end
			end
			s_ack: begin
				state_nxt = s_finish;
			end
			s_finish: begin
				state_nxt = s_idle;	// req drops here after ack
			end
			default: begin
				state_nxt = s_idle;
			end
		endcase
	end

	// control strobes to timer and datapath
	assign div_run    = (state == s_sclk_wait) || (state == s_last_half);
	assign edge_step  = (state == s_sclk_edge);
	assign xfer_start = (state == s_idle) && wr_req;
	assign wr_ack     = (state == s_ack);

	// sclk follows cpol in idle and toggles once per edge state
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			sclk <= 1'b0;
		end else if (state == s_idle) begin
			sclk <= cfg.cpol;
		end else if (edge_step) begin
			sclk <= ~sclk;
		end
	end

	a_ack_pulse: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_ack |=> !wr_ack
	) else $error("wr_ack held for more than one cycle");

	// an even number of toggles brings sclk back to its idle level
	a_sclk_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == s_finish) |=> (sclk == cfg.cpol)
	) else $error("sclk not at cpol on return to idle");

endmodule

`default_nettype wire

// File: spi_master_top.sv
// spi master top, ties sequencer, clock timer and shift datapath together
`timescale 1ns/1ps
`default_nettype none

module spi_master_top #(
	parameter int data_w = 8
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,

	input  spi_pkg::spi_cfg_t cfg,		// stable from req to ack
	input  logic              cs_ctrl,	// software chip select level

	input  logic              wr_req,
	output logic              wr_ack,
	input  logic [data_w-1:0] data_tx,
	output logic [data_w-1:0] data_rx,

	output logic              cs,
	output logic              sclk,
	output logic              mosi,
	input  logic              miso
);

	localparam int edge_w = $clog2(2 * data_w + 1);

	logic              div_run;
	logic              edge_step;
	logic              xfer_start;
	logic              div_done;
	logic              last_edge;
	logic [edge_w-1:0] edge_idx;

	assign cs = cs_ctrl;	// no automatic cs timing

	spi_ctrl_fsm u_fsm (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cfg       (cfg),
		.wr_req    (wr_req),
		.div_done  (div_done),
		.last_edge (last_edge),
		.div_run   (div_run),
		.edge_step (edge_step),
		.xfer_start(xfer_start),
		.sclk      (sclk),
		.wr_ack    (wr_ack)
	);

	spi_clk_timer #(
		.data_w(data_w)
	) u_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.clk_div   (cfg.clk_div),
		.div_run   (div_run),
		.edge_step (edge_step),
		.xfer_start(xfer_start),
		.div_done  (div_done),
		.last_edge (last_edge),
		.edge_idx  (edge_idx)
	);

	spi_shift_reg #(
		.data_w(data_w)
	) u_shift (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cpha      (cfg.cpha),
		.xfer_start(xfer_start),
		.edge_step (edge_step),
		.edge_idx  (edge_idx),
		.data_tx   (data_tx),
		.miso      (miso),
		.mosi      (mosi),
		.data_rx   (data_rx)
	);

endmodule

`default_nettype wire

// File: spi_pkg.sv
// spi master package with the divider width, fsm state encoding and run-time config
`default_nettype none

package spi_pkg;

	// half-period divider width
	localparam int div_w = 16;

	// transfer sequencer states
	typedef enum logic [2:0] {
		s_idle      = 3'd0,	// waiting for wr_req
		s_sclk_wait = 3'd1,	// counting one half period
		s_sclk_edge = 3'd2,	// one sclk edge
		s_last_half = 3'd3,	// trailing half period after last edge
		s_ack       = 3'd4,	// wr_ack pulse
		s_finish    = 3'd5	// spare cycle so a dropped req is not seen
	} spi_state_e;

	// run-time settings, held stable from wr_req to wr_ack
	typedef struct packed {
		logic             cpol;		// sclk idle level
		logic             cpha;		// 0 samples on odd-numbered edges
		logic [div_w-1:0] clk_div;	// half period is clk_div + 2 sys clocks
	} spi_cfg_t;

endpackage

`default_nettype wire

// File: spi_shift_reg.sv
// spi shift datapath, tx rotate register and rx shift register with cpha edge select
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg #(
	parameter  int data_w = 8,
	localparam int edge_w = $clog2(2 * data_w + 1)
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,

	input  logic              cpha,		// clock phase
	input  logic              xfer_start,	// load tx, clear rx
	input  logic              edge_step,	// sclk edge this cycle
	input  logic [edge_w-1:0] edge_idx,	// zero-based edge number
	input  logic [data_w-1:0] data_tx,
	input  logic              miso,

	output logic              mosi,
	output logic [data_w-1:0] data_rx
);

	logic [data_w-1:0] tx_shift;	// msb is on the wire
	logic [data_w-1:0] rx_shift;
	logic              idx_odd;
	logic              idx_zero;
	logic              shift_en;	// move next bit onto mosi
	logic              sample_en;	// capture miso

	assign idx_odd  = edge_idx[0];
	assign idx_zero = (edge_idx == '0);

	// cpha 0 samples on idx 0,2,.. and shifts on idx 1,3,..
	// cpha 1 shifts on idx 2,4,.. and samples on idx 1,3,..
	always_comb begin
		if (cpha) begin
			shift_en  = edge_step && !idx_odd && !idx_zero;
			sample_en = edge_step && idx_odd;
		end else begin
			shift_en  = edge_step && idx_odd;
			sample_en = edge_step && !idx_odd;
		end
	end

	// tx rotate register
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			tx_shift <= '0;
		end else if (xfer_start) begin
			tx_shift <= data_tx;
		end else if (shift_en) begin
			tx_shift <= {tx_shift[data_w-2:0], tx_shift[data_w-1]};	// rotate
		end
	end

	// rx register
	always_ff @(posedge sys_clk) begin
		if (xfer_start) begin
			rx_shift <= '0;
		end else if (sample_en) begin
			rx_shift <= {rx_shift[data_w-2:0], miso};	// msb first
		end
	end

	assign mosi    = tx_shift[data_w-1];
	assign data_rx = rx_shift;

endmodule

`default_nettype wire

// File: spi_slave_model.sv
// behavioural spi slave, captures mosi and shifts a preset word out on miso
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model #(
	parameter int data_w = 8
) (
	input  logic              cpol,
	input  logic              cpha,
	input  logic              cs,		// active low frame select
	input  logic              sclk,
	input  logic              mosi,
	input  logic [data_w-1:0] preset,	// word sent back to the master
	output logic              miso,
	output logic [data_w-1:0] captured
);

	logic [data_w-1:0] tx_sh = '0;
	logic [data_w-1:0] rx_sh = '0;
	logic              cs_q = 1'b1;
	logic              lvl_q = 1'b0;	// last seen sclk level
	int                edge_no = 0;
	logic              sample_edge;

	assign miso     = tx_sh[data_w-1];	// msb first
	assign captured = rx_sh;

	always @(cs or sclk) begin
		if (cs !== cs_q) begin
			cs_q = cs;
			if (cs == 1'b0) begin
				tx_sh   = preset;	// first bit out before any edge
				rx_sh   = '0;
				lvl_q   = cpol;
				edge_no = 0;
			end
		end else if (cs == 1'b0 && sclk !== lvl_q) begin
			lvl_q       = sclk;
			sample_edge = cpha ? (edge_no % 2 == 1) : (edge_no % 2 == 0);
			if (sample_edge) begin
				rx_sh = {rx_sh[data_w-2:0], mosi};
			end else if (edge_no != 0) begin
				tx_sh = {tx_sh[data_w-2:0], 1'b0};	// next bit onto miso
			end
			edge_no++;
		end
	end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset source, free-running clock with reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int half_period = 50,	// ns
	parameter int rst_cycles  = 5
) (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #(half_period) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (rst_cycles) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;	// released away from the sampling edge
	end

endmodule

`default_nettype wire

// File: tb_spi_master.sv
// spi master testbench, random words in all four spi modes against a behavioural slave
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;

	import spi_pkg::*;

	localparam int data_w = 8;

	logic              sys_clk;
	logic              sys_rst_n;
	spi_cfg_t          cfg;
	logic              cs_ctrl;
	logic              wr_req;
	logic              wr_ack;
	logic [data_w-1:0] data_tx;
	logic [data_w-1:0] data_rx;
	logic              cs;
	logic              sclk;
	logic              mosi;
	logic              miso;
	logic [data_w-1:0] slave_preset;
	logic [data_w-1:0] slave_captured;

	logic              between;	// no transfer running, sclk idles at cpol
	logic [31:0]       lfsr;
	string             cur_test;
	int                err_cnt;
	int                test_cnt;
	int                fail_cnt;
	bit                aborted;

	tb_clk_gen #(.half_period(50), .rst_cycles(5)) u_clk (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n)
	);

	spi_master_top #(.data_w(data_w)) u_dut (
		.sys_clk  (sys_clk),
		.sys_rst_n(sys_rst_n),
		.cfg      (cfg),
		.cs_ctrl  (cs_ctrl),
		.wr_req   (wr_req),
		.wr_ack   (wr_ack),
		.data_tx  (data_tx),
		.data_rx  (data_rx),
		.cs       (cs),
		.sclk     (sclk),
		.mosi     (mosi),
		.miso     (miso)
	);

	spi_slave_model #(.data_w(data_w)) u_slave (
		.cpol    (cfg.cpol),
		.cpha    (cfg.cpha),
		.cs      (cs),
		.sclk    (sclk),
		.mosi    (mosi),
		.preset  (slave_preset),
		.miso    (miso),
		.captured(slave_captured)
	);

	a_cs_follow: assert property (@(posedge sys_clk) cs == cs_ctrl)
	else begin
		$display("** Error %s cs: expected %b, actual %b", cur_test,
			$sampled(cs_ctrl), $sampled(cs));
		err_cnt++;
	end

	a_ack_single: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) wr_ack |=> !wr_ack
	) else begin
		$display("wr_ack stayed high for a second cycle during %s", cur_test);
		err_cnt++;
	end

	a_sclk_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) between |-> (sclk == cfg.cpol)
	) else begin
		$display("** Error %s sclk between transfers: expected %b, actual %b", cur_test,
			$sampled(cfg.cpol), $sampled(sclk));
		err_cnt++;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_byte(output logic [data_w-1:0] b);
		int i;
		b = '0;
		for (i = 0; i < data_w; i++) begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			b    = {b[data_w-2:0], lfsr[0]};
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	task automatic compare_value(input string what, input int unsigned expected,
			input int unsigned actual);
		assert (expected == actual) else begin
			$display("** Error %s %s: expected %0d, actual %0d", cur_test, what,
				expected, actual);
			err_cnt++;
		end
	endtask

	task automatic report_test(input int err_at_start);
		test_cnt++;
		if (err_cnt == err_at_start) begin
			$display("test %s passed", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s failed", cur_test);
		end
	endtask

	task automatic check_reset_state();
		int err_at_start;
		err_at_start = err_cnt;
		cur_test     = "reset_state";
		compare_value("wr_ack", 0, wr_ack);
		compare_value("sclk", 0, sclk);
		between = 1'b1;
		report_test(err_at_start);
	endtask

	// one full word in the given mode, checks both directions and latency
	task automatic run_xfer(input logic [1:0] mode, input int div);
		logic [data_w-1:0] tx_byte;
		logic [data_w-1:0] rx_byte;
		int                exp_lat;
		int                lat;
		int                err_at_start;
		bit                seen;
		err_at_start = err_cnt;
		cur_test     = $sformatf("mode%0d_div%0d", mode, div);
		exp_lat      = 1 + 2 * data_w * (div + 2) + (div + 1);
		draw_byte(tx_byte);
		draw_byte(rx_byte);
		between      = 1'b0;	// sclk follows the new cpol a cycle late
		cfg.cpol     = mode[1];
		cfg.cpha     = mode[0];
		cfg.clk_div  = div_w'(div);
		data_tx      = tx_byte;
		slave_preset = rx_byte;
		idle_cycles(3);
		between = 1'b1;
		cs_ctrl = 1'b0;
		@(negedge sys_clk);
		wr_req  = 1'b1;
		between = 1'b0;
		lat     = 0;
		seen    = 1'b0;
		while (!seen && lat < exp_lat + 20) begin
			@(negedge sys_clk);
			lat++;
			seen = wr_ack;
		end
		if (!seen) begin
			$display("timeout in %s: no wr_ack within %0d cycles", cur_test, lat);
			err_cnt++;
			aborted = 1'b1;
		end else begin
			compare_value("latency", exp_lat, lat);
			compare_value("slave captured", tx_byte, slave_captured);
			compare_value("data_rx", rx_byte, data_rx);
			between = 1'b1;
		end
		wr_req  = 1'b0;
		cs_ctrl = 1'b1;
		idle_cycles(3);	// back in idle before cfg may change
		report_test(err_at_start);
	endtask

	initial begin
		int waited;
		int d;
		int m;
		int div_val;
		cfg          = '0;
		cs_ctrl      = 1'b1;
		wr_req       = 1'b0;
		data_tx      = '0;
		slave_preset = '0;
		between      = 1'b0;
		lfsr         = 32'h026c_951b;
		cur_test     = "startup";
		err_cnt      = 0;
		test_cnt     = 0;
		fail_cnt     = 0;
		aborted      = 1'b0;
		waited       = 0;
		while (sys_rst_n !== 1'b1 && waited < 20) begin
			@(negedge sys_clk);
			waited++;
		end
		if (sys_rst_n !== 1'b1) begin
			$display("reset was never released by the clock generator");
			err_cnt++;
			aborted = 1'b1;
		end else begin
			@(negedge sys_clk);
			check_reset_state();
		end
		for (d = 0; d < 3; d++) begin
			div_val = (d == 0) ? 0 : (d == 1) ? 1 : 5;
			for (m = 0; m < 4; m++) begin
				if (!aborted) begin
					run_xfer(m[1:0], div_val);
				end
			end
		end
		$display("tests %0d, passed %0d, failed %0d, check failures %0d", test_cnt,
			test_cnt - fail_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
